// File: Makefile
TOP = camera_capture_tb

sim:
	verilator --binary --timing --top-module $(TOP) -f camera_capture.f -o $(TOP)
	./obj_dir/$(TOP) > sim.log 2>&1 || (cat sim.log; exit 1)
	@cat sim.log
	@if grep -qF '*** TEST FAILED ***' sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

// File: bench/camera_capture_tb.sv
`timescale 1ns/1ps
`default_nettype none

module camera_capture_tb;
  import camera_pkg::*;
  import stream_pkg::*;

  localparam int HRES      = 8;
  localparam int VRES      = 4;
  localparam int FB_AW     = $clog2((HRES / 2) * (VRES / 2));
  localparam int LINE_CYC  = HRES * 2 * 4 + 6;  // 4 cycles per byte plus hsync gap
  localparam int FRAME_CYC = VRES * LINE_CYC + 10;
  localparam int LIMIT     = 2 * (4 * FRAME_CYC + 100);  // four frames plus idle and drain

  logic               clk_camera = 1'b0;
  logic               sys_rst_camera;
  logic [BYTE_W-1:0]  camera_d;
  logic               cam_pclk;
  logic               cam_hsync;
  logic               cam_vsync;
  logic               chunk_tready;
  logic [FB_AW-1:0]   fb_addr;
  logic [PIXEL_W-1:0] fb_data;
  logic               fb_wr_en;
  logic [CHUNK_W-1:0] chunk_tdata;
  logic               chunk_tvalid;
  logic               chunk_tlast;
  logic               overflow;

  integer             seed = 41;
  int                 cycles = 0;
  int                 fb_errors = 0;     // write path mismatches
  int                 chunk_errors = 0;  // chunk stream mismatches
  int                 chk_errors = 0;    // direct checks in the sequence
  int                 tests_ok = 0;
  int                 tests_bad = 0;
  logic [BYTE_W-1:0]  frame_b [0:2*HRES*VRES-1];
  logic [BYTE_W-1:0]  carry_b [0:CHUNK_BYTES-1];  // luma left in a partial chunk
  int                 carry_n = 0;
  int                 exp_addr [0:63];
  logic [PIXEL_W-1:0] exp_data [0:63];
  logic [CHUNK_W-1:0] exp_chunk [0:15];
  logic               exp_last [0:15];
  int                 fb_total = 0;
  int                 fb_seen = 0;
  int                 chunk_total = 0;
  int                 chunk_seen = 0;
  logic               held = 1'b0;
  logic [CHUNK_W-1:0] held_data;

  camera_capture_top #(.HRES(HRES), .VRES(VRES)) DUT (.*);

  always #10 clk_camera = ~clk_camera;

  // pixel at (x, y) with the first bus byte as its upper half
  function automatic logic [PIXEL_W-1:0] ref_pixel(input int x, input int y);
    return {frame_b[2 * (y * HRES + x)], frame_b[2 * (y * HRES + x) + 1]};
  endfunction

  function automatic int ref_addr(input int x, input int y);
    return x / 2 + (y / 2) * (HRES / 2);
  endfunction

  // byte s of the luma stream with carried bytes ahead of this frame
  function automatic logic [BYTE_W-1:0] stream_byte(input int s, input int npix);
    logic [PIXEL_W-1:0] pix;
    int                 p;
    p = s - carry_n;
    if (s < carry_n) return carry_b[s];
    if (p >= npix) return '0;  // zero fill past frame end
    pix = ref_pixel(p % HRES, p / HRES);
    return pix[BYTE_W-1:0];
  endfunction

  function automatic logic [CHUNK_W-1:0] ref_chunk(input int k, input int npix);
    logic [CHUNK_W-1:0] c;
    c = '0;
    for (int i = 0; i < CHUNK_BYTES; i++) begin
      c[i*BYTE_W +: BYTE_W] = stream_byte(k * CHUNK_BYTES + i, npix);
    end
    return c;
  endfunction

  task automatic send_byte(input logic [BYTE_W-1:0] b);
    camera_d = b;
    cam_pclk = 1'b0;
    repeat (2) @(negedge clk_camera);
    cam_pclk = 1'b1;
    repeat (2) @(negedge clk_camera);
  endtask

  // fills expectations for one frame, then plays it on the camera bus
  task automatic run_frame(input int lines, input bit stall);
    int                npix;
    int                nbytes;
    int                nchunks;
    int                keep;
    logic [BYTE_W-1:0] tail [0:CHUNK_BYTES-1];
    npix = HRES * lines;
    for (int i = 0; i < 2 * npix; i++) frame_b[i] = 8'($random(seed));
    for (int y = 0; y < lines; y += 2) begin
      for (int x = 0; x < HRES; x += 2) begin
        exp_addr[fb_total] = ref_addr(x, y);
        exp_data[fb_total] = ref_pixel(x, y);
        fb_total++;
      end
    end
    nbytes  = carry_n + npix;
    nchunks = (lines == VRES) ? (nbytes + CHUNK_BYTES - 1) / CHUNK_BYTES : nbytes / CHUNK_BYTES;
    if (stall) nchunks = 1;  // rest of the frame is dropped
    for (int k = 0; k < nchunks; k++) begin
      exp_chunk[chunk_total] = ref_chunk(k, npix);
      exp_last[chunk_total]  = (lines == VRES) && !stall && (k == nchunks - 1);
      chunk_total++;
    end
    keep = (lines == VRES || stall) ? 0 : nbytes % CHUNK_BYTES;
    for (int i = 0; i < keep; i++) tail[i] = stream_byte(nchunks * CHUNK_BYTES + i, npix);
    for (int i = 0; i < keep; i++) carry_b[i] = tail[i];
    carry_n   = keep;
    cam_vsync = 1'b1;
    for (int y = 0; y < lines; y++) begin
      cam_hsync = 1'b1;
      for (int i = 0; i < 2 * HRES; i++) send_byte(frame_b[2 * HRES * y + i]);
      cam_hsync = 1'b0;
      cam_pclk  = 1'b0;
      repeat (6) @(negedge clk_camera);
    end
    cam_vsync = 1'b0;
    repeat (10) @(negedge clk_camera);
  endtask

  task automatic drain();
    while (fb_seen < fb_total || chunk_seen < chunk_total) @(negedge clk_camera);
    repeat (4) @(negedge clk_camera);  // room for a stray strobe
  endtask

  task automatic report(input string name, input int bad);
    if (bad == 0) begin
      $display("test %s: ok", name);
      tests_ok++;
    end else begin
      $display("test %s: %0d errors", name, bad);
      tests_bad++;
    end
  endtask

  always @(posedge clk_camera) begin
    if (!sys_rst_camera) begin
      if (fb_wr_en) begin
        if (fb_seen >= fb_total) begin
          $display("%0t: frame-buffer write when none was due", $time);
          fb_errors++;
        end else begin
          assert (int'(fb_addr) == exp_addr[fb_seen] && fb_data == exp_data[fb_seen]) else begin
            $display("[FAIL] %0t: write %0d addr %0d data %h, expected addr %0d data %h",
                     $time, fb_seen, fb_addr, fb_data, exp_addr[fb_seen], exp_data[fb_seen]);
            fb_errors++;
          end
          fb_seen++;
        end
      end
      if (chunk_tvalid && chunk_tready) begin
        if (chunk_seen >= chunk_total) begin
          $display("%0t: chunk transfer when none was due", $time);
          chunk_errors++;
        end else begin
          assert (chunk_tdata == exp_chunk[chunk_seen] && chunk_tlast == exp_last[chunk_seen])
            else begin
            $display("[FAIL] %0t: chunk %0d is %h last %b, expected %h last %b", $time,
                     chunk_seen, chunk_tdata, chunk_tlast, exp_chunk[chunk_seen],
                     exp_last[chunk_seen]);
            chunk_errors++;
          end
          chunk_seen++;
        end
      end
      if (held) begin  // refused chunk must stay put
        assert (chunk_tvalid && chunk_tdata == held_data) else begin
          $display("[FAIL] %0t: refused chunk was dropped or changed", $time);
          chunk_errors++;
        end
      end
      held      = chunk_tvalid && !chunk_tready;
      held_data = chunk_tdata;
    end
  end

  always @(posedge clk_camera) begin
    cycles++;
    if (cycles > LIMIT) begin
      $display("timeout: the tests did not finish within %0d cycles", LIMIT);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  initial begin
    int b_fb;
    int b_ch;
    int b_chk;
    sys_rst_camera = 1'b1;
    camera_d       = '0;
    cam_pclk       = 1'b0;
    cam_hsync      = 1'b0;
    cam_vsync      = 1'b0;
    chunk_tready   = 1'b1;
    repeat (4) @(negedge clk_camera);
    sys_rst_camera = 1'b0;

    b_chk = chk_errors;
    repeat (20) begin
      @(negedge clk_camera);
      assert (!fb_wr_en && !chunk_tvalid && !chunk_tlast && !overflow) else begin
        $display("[FAIL] %0t: strobe or overflow high with the camera idle", $time);
        chk_errors++;
      end
    end
    report("idle after reset", chk_errors - b_chk);

    // one frame with the consumer always ready
    b_fb  = fb_errors;
    b_ch  = chunk_errors;
    b_chk = chk_errors;
    run_frame(VRES, 1'b0);
    drain();
    assert (!overflow) else begin
      $display("[FAIL] %0t: overflow set with the consumer ready", $time);
      chk_errors++;
    end
    report("frame-buffer writes", fb_errors - b_fb);
    report("luma chunks", chunk_errors - b_ch + chk_errors - b_chk);

    b_fb  = fb_errors;
    b_ch  = chunk_errors;
    b_chk = chk_errors;
    chunk_tready = 1'b0;
    run_frame(VRES, 1'b1);
    while (fb_seen < fb_total) @(negedge clk_camera);
    assert (chunk_tvalid && overflow) else begin
      $display("[FAIL] %0t: no held chunk or no overflow after a stalled frame", $time);
      chk_errors++;
    end
    chunk_tready = 1'b1;
    drain();
    report("stalled consumer", fb_errors - b_fb + chunk_errors - b_ch + chk_errors - b_chk);

    // short frame cut by vsync, then a full one
    b_fb  = fb_errors;
    b_ch  = chunk_errors;
    run_frame(VRES - 1, 1'b0);
    drain();
    run_frame(VRES, 1'b0);
    drain();
    report("short frame", fb_errors - b_fb + chunk_errors - b_ch);

    $display("tests passed %0d, failed %0d", tests_ok, tests_bad);
    if (tests_bad == 0 && fb_errors + chunk_errors + chk_errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: camera_capture.f
logic/camera_pkg.sv
logic/stream_pkg.sv
logic/camera_sync.sv
logic/pixel_reconstruct.sv
logic/frame_downsampler.sv
logic/pixel_stacker.sv
logic/camera_capture_top.sv
bench/camera_capture_tb.sv

// File: logic/camera_capture_top.sv
`timescale 1ns/1ps
`default_nettype none

module camera_capture_top #(
  parameter int HRES = camera_pkg::DEF_HRES,
  parameter int VRES = camera_pkg::DEF_VRES
) (
  input  logic                                 clk_camera,
  input  logic                                 sys_rst_camera,
  input  logic [camera_pkg::BYTE_W-1:0]          camera_d,
  input  logic                                 cam_pclk,
  input  logic                                 cam_hsync,
  input  logic                                 cam_vsync,
  input  logic                                 chunk_tready,
  output logic [$clog2((HRES/2)*(VRES/2))-1:0] fb_addr,
  output logic [camera_pkg::PIXEL_W-1:0]         fb_data,
  output logic                                 fb_wr_en,
  output logic [stream_pkg::CHUNK_W-1:0]         chunk_tdata,
  output logic                                 chunk_tvalid,
  output logic                                 chunk_tlast,
  output logic                                 overflow
);
  import camera_pkg::*;

  localparam int HC_W = $clog2(HRES);
  localparam int VC_W = $clog2(VRES);

  // synchronised camera bus
  logic [BYTE_W-1:0]  sync_d;
  logic               sync_hsync;
  logic               sync_vsync;
  logic               pclk_rise;

  // reconstructed pixel stream, shared by both consumers
  logic               pix_valid;
  logic [PIXEL_W-1:0] pix_data;
  logic [HC_W-1:0]    pix_hcount;
  logic [VC_W-1:0]    pix_vcount;
  logic               pix_last;

  camera_sync u_sync (
    .clk_camera(clk_camera), .sys_rst_camera(sys_rst_camera),
    .camera_d(camera_d), .cam_pclk(cam_pclk),
    .cam_hsync(cam_hsync), .cam_vsync(cam_vsync),
    .sync_d(sync_d), .sync_hsync(sync_hsync),
    .sync_vsync(sync_vsync), .pclk_rise(pclk_rise)
  );

  pixel_reconstruct #(.HRES(HRES), .VRES(VRES)) u_reconstruct (
    .clk_camera(clk_camera), .sys_rst_camera(sys_rst_camera),
    .sync_d(sync_d), .sync_hsync(sync_hsync),
    .sync_vsync(sync_vsync), .pclk_rise(pclk_rise),
    .pix_valid(pix_valid), .pix_data(pix_data),
    .pix_hcount(pix_hcount), .pix_vcount(pix_vcount), .pix_last(pix_last)
  );

  frame_downsampler #(.HRES(HRES), .VRES(VRES)) u_downsample (
    .clk_camera(clk_camera), .sys_rst_camera(sys_rst_camera),
    .pix_valid(pix_valid), .pix_data(pix_data),
    .pix_hcount(pix_hcount), .pix_vcount(pix_vcount),
    .fb_addr(fb_addr), .fb_data(fb_data), .fb_wr_en(fb_wr_en)
  );

  pixel_stacker u_stacker (
    .clk_camera(clk_camera), .sys_rst_camera(sys_rst_camera),
    .pix_valid(pix_valid), .pix_data(pix_data), .pix_last(pix_last),
    .chunk_tready(chunk_tready), .chunk_tdata(chunk_tdata),
    .chunk_tvalid(chunk_tvalid), .chunk_tlast(chunk_tlast), .overflow(overflow)
  );

endmodule

`default_nettype wire

// File: logic/camera_pkg.sv
`default_nettype none

package camera_pkg;

  // parallel sensor bus, one byte per pclk
  localparam int BYTE_W = 8;

  // two bytes make one pixel, first byte is the upper half
  localparam int PIXEL_W = 2 * BYTE_W;

  // native sensor resolution
  localparam int DEF_HRES = 1280;
  localparam int DEF_VRES = 720;

  // which byte of the pair we are waiting for
  typedef enum logic {
    BYTE_HIGH = 1'b0,
    BYTE_LOW  = 1'b1
  } byte_phase_t;

endpackage

`default_nettype wire

// File: logic/camera_sync.sv
`timescale 1ns/1ps
`default_nettype none

module camera_sync (
  input  logic                        clk_camera,
  input  logic                        sys_rst_camera,
  input  logic [camera_pkg::BYTE_W-1:0] camera_d,
  input  logic                        cam_pclk,
  input  logic                        cam_hsync,
  input  logic                        cam_vsync,
  output logic [camera_pkg::BYTE_W-1:0] sync_d,
  output logic                        sync_hsync,
  output logic                        sync_vsync,
  output logic                        pclk_rise
);
  import camera_pkg::*;

  logic [BYTE_W-1:0] d_meta;
  logic [2:0]        ctl_meta;  // {vsync, hsync, pclk}
  logic              pclk_sync;
  logic              pclk_prev;

  // two flops for the data byte
  always_ff @(posedge clk_camera) begin
    d_meta <= camera_d;
    sync_d <= d_meta;
  end

  always_ff @(posedge clk_camera) begin
    if (sys_rst_camera) begin
      ctl_meta   <= 3'b000;
      pclk_sync  <= 1'b0;
      sync_hsync <= 1'b0;
      sync_vsync <= 1'b0;
      pclk_prev  <= 1'b0;
    end else begin
      ctl_meta   <= {cam_vsync, cam_hsync, cam_pclk};
      pclk_sync  <= ctl_meta[0];
      sync_hsync <= ctl_meta[1];
      sync_vsync <= ctl_meta[2];
      pclk_prev  <= pclk_sync;  // edge detect on the clean copy
    end
  end

  assign pclk_rise = pclk_sync & ~pclk_prev;

endmodule

`default_nettype wire

// File: logic/frame_downsampler.sv
`timescale 1ns/1ps
`default_nettype none

module frame_downsampler #(
  parameter int HRES = camera_pkg::DEF_HRES,
  parameter int VRES = camera_pkg::DEF_VRES
) (
  input  logic                                    clk_camera,
  input  logic                                    sys_rst_camera,
  input  logic                                    pix_valid,
  input  logic [camera_pkg::PIXEL_W-1:0]            pix_data,
  input  logic [$clog2(HRES)-1:0]                 pix_hcount,
  input  logic [$clog2(VRES)-1:0]                 pix_vcount,
  output logic [$clog2((HRES/2)*(VRES/2))-1:0]    fb_addr,
  output logic [camera_pkg::PIXEL_W-1:0]            fb_data,
  output logic                                    fb_wr_en
);

  localparam int FB_AW = $clog2((HRES / 2) * (VRES / 2));

  logic keep;  // even column on an even row

  assign keep = pix_valid & ~pix_hcount[0] & ~pix_vcount[0];

  always_ff @(posedge clk_camera) begin
    if (sys_rst_camera) begin
      fb_wr_en <= 1'b0;
    end else begin
      fb_wr_en <= keep;
    end
  end

  // x/2 + (y/2)*w/2, quarter-size image
  always_ff @(posedge clk_camera) begin
    if (pix_valid) begin
      fb_addr <= FB_AW'(pix_hcount >> 1) + FB_AW'((pix_vcount >> 1) * (HRES / 2));
      fb_data <= pix_data;
    end
  end

endmodule

`default_nettype wire

// File: logic/pixel_reconstruct.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_reconstruct #(
  parameter int HRES = camera_pkg::DEF_HRES,
  parameter int VRES = camera_pkg::DEF_VRES
) (
  input  logic                         clk_camera,
  input  logic                         sys_rst_camera,
  input  logic [camera_pkg::BYTE_W-1:0]  sync_d,
  input  logic                         sync_hsync,
  input  logic                         sync_vsync,
  input  logic                         pclk_rise,
  output logic                         pix_valid,
  output logic [camera_pkg::PIXEL_W-1:0] pix_data,
  output logic [$clog2(HRES)-1:0]      pix_hcount,
  output logic [$clog2(VRES)-1:0]      pix_vcount,
  output logic                         pix_last
);
  import camera_pkg::*;

  localparam int HC_W = $clog2(HRES);
  localparam int VC_W = $clog2(VRES);

  byte_phase_t       phase;
  logic [BYTE_W-1:0] high_byte;   // first byte of the pair
  logic [HC_W-1:0]   hcount;
  logic [VC_W-1:0]   vcount;
  logic              hsync_prev;
  logic              hsync_fall;
  logic              capture;
  logic              take_low;

  assign hsync_fall = hsync_prev & ~sync_hsync;
  assign capture    = pclk_rise & sync_hsync & sync_vsync;
  assign take_low   = capture && (phase == BYTE_LOW);

  always_ff @(posedge clk_camera) begin
    if (sys_rst_camera) begin
      phase      <= BYTE_HIGH;
      hcount     <= '0;
      vcount     <= '0;
      hsync_prev <= 1'b0;
      pix_valid  <= 1'b0;
      pix_last   <= 1'b0;
      pix_hcount <= '0;
      pix_vcount <= '0;
    end else begin
      hsync_prev <= sync_hsync;
      pix_valid  <= 1'b0;
      if (!sync_vsync) begin
        // between frames, everything back to the origin
        phase  <= BYTE_HIGH;
        hcount <= '0;
        vcount <= '0;
      end else if (hsync_fall) begin
        phase  <= BYTE_HIGH;
        hcount <= '0;
        vcount <= vcount + 1'b1;
      end else if (capture) begin
        if (phase == BYTE_HIGH) begin
          phase <= BYTE_LOW;
        end else begin
          phase      <= BYTE_HIGH;
          pix_valid  <= 1'b1;
          pix_hcount <= hcount;
          pix_vcount <= vcount;
          pix_last   <= (hcount == HC_W'(HRES - 1)) && (vcount == VC_W'(VRES - 1));
          hcount     <= hcount + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_camera) begin
    if (capture && phase == BYTE_HIGH) high_byte <= sync_d;
    if (take_low) pix_data <= {high_byte, sync_d};  // upper byte came first
  end

endmodule

`default_nettype wire

// File: logic/pixel_stacker.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_stacker (
  input  logic                           clk_camera,
  input  logic                           sys_rst_camera,
  input  logic                           pix_valid,
  input  logic [camera_pkg::PIXEL_W-1:0]   pix_data,
  input  logic                           pix_last,
  input  logic                           chunk_tready,
  output logic [stream_pkg::CHUNK_W-1:0]   chunk_tdata,
  output logic                           chunk_tvalid,
  output logic                           chunk_tlast,
  output logic                           overflow
);
  import camera_pkg::*;
  import stream_pkg::*;

  localparam int FILL_W = $clog2(CHUNK_BYTES);

  stack_state_t      state;
  logic [FILL_W-1:0] fill;      // next byte slot
  logic [BYTE_W-1:0] luma;
  logic              accept;
  logic              close;

  assign luma   = pix_data[BYTE_W-1:0];  // low byte is Y
  assign accept = pix_valid && (state == STACK_FILL);
  assign close  = accept && (pix_last || fill == FILL_W'(CHUNK_BYTES - 1));

  always_ff @(posedge clk_camera) begin
    if (sys_rst_camera) begin
      state       <= STACK_FILL;
      fill        <= '0;
      chunk_tlast <= 1'b0;
      overflow    <= 1'b0;
    end else begin
      case (state)
        STACK_FILL: begin
          if (close) begin
            state       <= STACK_HOLD;
            fill        <= '0;
            chunk_tlast <= pix_last;  // early close at frame end
          end else if (accept) begin
            fill <= fill + 1'b1;
          end
        end
        STACK_HOLD: begin
          if (pix_valid) overflow <= 1'b1;  // byte lost, sticky until reset
          if (chunk_tready) begin
            state       <= STACK_FILL;
            chunk_tlast <= 1'b0;
          end
        end
        default: state <= STACK_FILL;
      endcase
    end
  end

  // slot 0 wipes the rest, so a short chunk is zero filled
  always_ff @(posedge clk_camera) begin
    if (accept) begin
      if (fill == '0) begin
        chunk_tdata <= CHUNK_W'(luma);
      end else begin
        chunk_tdata[fill*BYTE_W +: BYTE_W] <= luma;
      end
    end
  end

  assign chunk_tvalid = (state == STACK_HOLD);

endmodule

`default_nettype wire

// File: logic/stream_pkg.sv
`default_nettype none

package stream_pkg;

  // memory-writer word, 16 luminance bytes
  localparam int CHUNK_W     = 128;
  localparam int CHUNK_BYTES = 16;

  typedef enum logic {
    STACK_FILL = 1'b0,  // gathering bytes
    STACK_HOLD = 1'b1   // full chunk offered downstream
  } stack_state_t;

endpackage

`default_nettype wire
